// File: rtl/efuse_macros.svh
// Fuse repair path constants
// Repair word widths, APB register map and serial link latency
`ifndef EFUSE_MACROS_SVH
`define EFUSE_MACROS_SVH

// Repair word and serial address
`define FUSE_W       16
`define FUSE_ADDR_W  6

// Bank geometry, ids 6 and 7 are not backed by a register
`define FUSE_NSUB    4
`define FUSE_NRID    6

// Dshift out to read bit back, and idle tail before done
`define FUSE_RD_LAT  4
`define FUSE_DRAIN   `FUSE_RD_LAT

// APB register offsets
`define REG_CTRL     8'h00
`define REG_ADDR     8'h04
`define REG_WDATA    8'h08
`define REG_RDATA    8'h0C
`define REG_STATUS   8'h10

`endif

// File: rtl/efuse_pkg.sv
// Fuse repair path types
// Command, response, serial link and bank enable bundles
`default_nettype none

`include "efuse_macros.svh"

package efuse_pkg;

   // Serial address, first field is shifted out first
   typedef struct packed {
      logic [1:0] subbank;
      logic [2:0] rid;
      logic       wren;
   } fuse_addr_t;

   // Register block to sequencer
   typedef struct packed {
      fuse_addr_t         addr;
      logic [`FUSE_W-1:0] wdata;
   } fuse_cmd_t;

   // Sequencer back to register block
   typedef struct packed {
      logic               busy;
      logic               done;
      logic [`FUSE_W-1:0] rdata;
   } fuse_rsp_t;

   // Serial link into the data-side header
   typedef struct packed {
      logic ashift;
      logic dshift;
      logic data;
   } fuse_link_t;

   // Per-register strobes into the redundancy bank
   typedef struct packed {
      logic [`FUSE_NSUB-1:0][`FUSE_NRID-1:0] wren;
      logic [`FUSE_NSUB-1:0][`FUSE_NRID-1:0] rdshift;
      logic                                  data;
   } fuse_en_t;

endpackage

`default_nettype wire

// File: rtl/efuse_regs.sv
// Fuse controller APB registers
// Holds address, write word and op, launches the sequencer and refuses bad writes
`timescale 1ns/1ns
`default_nettype none

`include "efuse_macros.svh"

module efuse_regs (
   input  wire                  rclk,
   input  wire                  rst,
   input  wire                  psel,
   input  wire                  penable,
   input  wire                  pwrite,
   input  wire [7:0]            paddr,
   input  wire [31:0]           pwdata,
   output logic [31:0]          prdata,
   output logic                 pready,
   output logic                 pslverr,
   output logic                 start,
   output efuse_pkg::fuse_cmd_t cmd,
   input  wire efuse_pkg::fuse_rsp_t rsp
);

   logic               acc;
   logic               wr_acc;
   logic               hit_ctrl;
   logic               hit_addr;
   logic               hit_wdata;
   logic               hit_rdata;
   logic               hit_status;
   logic               mapped;
   logic               busy_now;
   logic               wr_bad;
   logic               wr_ok;
   logic               go;
   logic [1:0]         sub_q;
   logic [2:0]         rid_q;
   logic               op_q;
   logic [`FUSE_W-1:0] wdata_q;

   // -------------------------------------------------------------------------
   // Access decode
   // -------------------------------------------------------------------------
   assign acc        = psel & penable;
   assign wr_acc     = acc & pwrite;
   assign hit_ctrl   = (paddr == `REG_CTRL);
   assign hit_addr   = (paddr == `REG_ADDR);
   assign hit_wdata  = (paddr == `REG_WDATA);
   assign hit_rdata  = (paddr == `REG_RDATA);
   assign hit_status = (paddr == `REG_STATUS);
   assign mapped     = hit_ctrl | hit_addr | hit_wdata | hit_rdata | hit_status;

   // Start pulse counts as busy until the sequencer catches up
   assign busy_now = rsp.busy | start;

   // Read-only targets, bad id, or start during an operation
   assign wr_bad = hit_rdata | hit_status
                 | (hit_addr & (pwdata[2:0] >= `FUSE_NRID))
                 | (hit_ctrl & pwdata[0] & busy_now);

   assign pready  = 1'b1;
   assign pslverr = acc & (~mapped | (pwrite & wr_bad));
   assign wr_ok   = wr_acc & ~pslverr;
   assign go      = wr_ok & hit_ctrl & pwdata[0];

   // -------------------------------------------------------------------------
   // Software visible registers
   // -------------------------------------------------------------------------
   always_ff @(posedge rclk) begin
      if (rst) begin
         start   <= 1'b0;
         op_q    <= 1'b0;
         sub_q   <= '0;
         rid_q   <= '0;
         wdata_q <= '0;
      end else begin
         start <= go;
         if (wr_ok & hit_ctrl) begin
            op_q <= pwdata[1];
         end
         if (wr_ok & hit_addr) begin
            sub_q <= pwdata[4:3];
            rid_q <= pwdata[2:0];
         end
         if (wr_ok & hit_wdata) begin
            wdata_q <= pwdata[`FUSE_W-1:0];
         end
      end
   end

   // Snapshot at launch so the sequencer sees a stable command
   always_ff @(posedge rclk) begin
      if (go) begin
         cmd.addr.subbank <= sub_q;
         cmd.addr.rid     <= rid_q;
         cmd.addr.wren    <= pwdata[1];
         cmd.wdata        <= wdata_q;
      end
   end

   // Read mux
   always_comb begin
      prdata = '0;
      if (hit_ctrl) begin
         prdata = {30'd0, op_q, 1'b0};
      end else if (hit_addr) begin
         prdata = {27'd0, sub_q, rid_q};
      end else if (hit_wdata) begin
         prdata = {{(32-`FUSE_W){1'b0}}, wdata_q};
      end else if (hit_rdata) begin
         prdata = {{(32-`FUSE_W){1'b0}}, rsp.rdata};
      end else if (hit_status) begin
         prdata = {30'd0, rsp.done, busy_now};
      end
   end

endmodule

`default_nettype wire

// File: rtl/efuse_seq.sv
// Serial fuse sequencer
// Shifts the address out, then shifts write data or collects read bits
`timescale 1ns/1ns
`default_nettype none

`include "efuse_macros.svh"

module efuse_seq (
   input  wire                   rclk,
   input  wire                   rst,
   input  wire                   start,
   input  wire efuse_pkg::fuse_cmd_t cmd,
   output efuse_pkg::fuse_rsp_t  rsp,
   output efuse_pkg::fuse_link_t link,
   input  wire                   scdata_efc_fuse_data
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ADDR,
      ST_DATA,
      ST_DRAIN
   } state_t;

   state_t                          state;
   logic [4:0]                      cnt;
   logic                            last;
   logic [`FUSE_ADDR_W+`FUSE_W-1:0] sr;
   logic [`FUSE_RD_LAT-1:0]         dshift_dly;
   logic                            done_q;
   logic [`FUSE_W-1:0]              rdata_q;

   // Write word goes out LSB first behind an MSB-first address
   function automatic logic [`FUSE_W-1:0] bit_rev(input logic [`FUSE_W-1:0] v);
      logic [`FUSE_W-1:0] r;
      for (int i = 0; i < `FUSE_W; i++) begin
         r[i] = v[`FUSE_W-1-i];
      end
      return r;
   endfunction

   // -------------------------------------------------------------------------
   // Phase control
   // -------------------------------------------------------------------------
   always_comb begin
      case (state)
         ST_ADDR:  last = (cnt == 5'(`FUSE_ADDR_W - 1));
         ST_DATA:  last = (cnt == 5'(`FUSE_W - 1));
         ST_DRAIN: last = (cnt == 5'(`FUSE_DRAIN - 1));
         default:  last = 1'b0;
      endcase
   end

   // A new start always restarts from the address phase
   always_ff @(posedge rclk) begin
      if (rst) begin
         state  <= ST_IDLE;
         cnt    <= '0;
         done_q <= 1'b0;
      end else if (start) begin
         state  <= ST_ADDR;
         cnt    <= '0;
         done_q <= 1'b0;
      end else if (state != ST_IDLE) begin
         cnt <= last ? 5'd0 : cnt + 5'd1;
         if (last) begin
            case (state)
               ST_ADDR: state <= ST_DATA;
               ST_DATA: state <= ST_DRAIN;
               default: begin
                  state  <= ST_IDLE;
                  done_q <= 1'b1;
               end
            endcase
         end
      end
   end

   // Serializer, top bit is on the link
   always_ff @(posedge rclk) begin
      if (start) begin
         sr <= {cmd.addr, bit_rev(cmd.wdata)};
      end else if (state == ST_ADDR || state == ST_DATA) begin
         sr <= {sr[`FUSE_ADDR_W+`FUSE_W-2:0], 1'b0};
      end
   end

   // -------------------------------------------------------------------------
   // Read return
   // -------------------------------------------------------------------------
   // Dshift echo lines up with the bit coming back from the header
   always_ff @(posedge rclk) begin
      if (rst) begin
         dshift_dly <= '0;
         rdata_q    <= '0;
      end else begin
         dshift_dly <= {dshift_dly[`FUSE_RD_LAT-2:0], link.dshift};
         if (dshift_dly[`FUSE_RD_LAT-1] & ~cmd.addr.wren) begin
            rdata_q <= {scdata_efc_fuse_data, rdata_q[`FUSE_W-1:1]};
         end
      end
   end

   always_comb begin
      link.ashift = (state == ST_ADDR);
      link.dshift = (state == ST_DATA);
      link.data   = sr[`FUSE_ADDR_W+`FUSE_W-1] & (link.ashift | link.dshift);
   end

   always_comb begin
      rsp.busy  = (state != ST_IDLE);
      rsp.done  = done_q;
      rsp.rdata = rdata_q;
   end

endmodule

`default_nettype wire

// File: rtl/scdata_fuse_hdr.sv
// Data-side fuse header
// Collects the serial address, decodes per-register strobes and stages data
`timescale 1ns/1ns
`default_nettype none

`include "efuse_macros.svh"

module scdata_fuse_hdr (
   input  wire                  rclk,
   input  wire                  rst,
   input  wire efuse_pkg::fuse_link_t link,
   output efuse_pkg::fuse_en_t  en,
   input  wire                  red_fuse_data,
   output logic                 scdata_efc_fuse_data
);

   efuse_pkg::fuse_addr_t                 addr_sr;
   logic                                  dshift_d1;
   logic                                  wr_go;
   logic                                  rd_go;
   logic [`FUSE_NSUB-1:0][`FUSE_NRID-1:0] sel;
   logic [`FUSE_NSUB-1:0][`FUSE_NRID-1:0] wren_q;
   logic [`FUSE_NSUB-1:0][`FUSE_NRID-1:0] rdshift_q;
   logic                                  data_in_d1;
   logic                                  data_in_d2;
   logic                                  data_out_d1;

   // -------------------------------------------------------------------------
   // Address capture
   // -------------------------------------------------------------------------
   // Subbank arrives first and ends up in the top bits
   always_ff @(posedge rclk) begin
      if (rst) begin
         addr_sr <= '0;
      end else if (link.ashift) begin
         addr_sr <= {addr_sr[`FUSE_ADDR_W-2:0], link.data};
      end
   end

   // -------------------------------------------------------------------------
   // Subbank and id decode
   // -------------------------------------------------------------------------
   // Ids 6 and 7 match nothing
   always_comb begin
      for (int s = 0; s < `FUSE_NSUB; s++) begin
         for (int r = 0; r < `FUSE_NRID; r++) begin
            sel[s][r] = (addr_sr.subbank == 2'(s)) && (addr_sr.rid == 3'(r));
         end
      end
   end

   // First strobe stage
   always_ff @(posedge rclk) begin
      if (rst) begin
         dshift_d1 <= 1'b0;
      end else begin
         dshift_d1 <= link.dshift;
      end
   end

   assign wr_go = dshift_d1 & addr_sr.wren;
   assign rd_go = dshift_d1 & ~addr_sr.wren;

   // Second strobe stage, one line per register
   always_ff @(posedge rclk) begin
      if (rst) begin
         wren_q    <= '0;
         rdshift_q <= '0;
      end else begin
         wren_q    <= wr_go ? sel : '0;
         rdshift_q <= rd_go ? sel : '0;
      end
   end

   // -------------------------------------------------------------------------
   // Data staging
   // -------------------------------------------------------------------------
   // Two stages in and two stages out
   always_ff @(posedge rclk) begin
      data_in_d1           <= link.data;
      data_in_d2           <= data_in_d1;
      data_out_d1          <= red_fuse_data;
      scdata_efc_fuse_data <= data_out_d1;
   end

   always_comb begin
      en.wren    = wren_q;
      en.rdshift = rdshift_q;
      en.data    = data_in_d2;
   end

endmodule

`default_nettype wire

// File: rtl/red_fuse_bank.sv
// Redundancy register bank
// Four subbanks of six repair words with serial write and rotating read
`timescale 1ns/1ns
`default_nettype none

`include "efuse_macros.svh"

module red_fuse_bank (
   input  wire                 rclk,
   input  wire                 rst,
   input  wire efuse_pkg::fuse_en_t en,
   output logic                red_fuse_data
);

   logic [`FUSE_NSUB-1:0][`FUSE_NRID-1:0][`FUSE_W-1:0] red_q;

   // -------------------------------------------------------------------------
   // Register array
   // -------------------------------------------------------------------------
   // Write shifts in at the MSB
   // Read rotates so a full pass leaves the word as it was
   always_ff @(posedge rclk) begin
      if (rst) begin
         red_q <= '0;
      end else begin
         for (int s = 0; s < `FUSE_NSUB; s++) begin
            for (int r = 0; r < `FUSE_NRID; r++) begin
               if (en.wren[s][r]) begin
                  red_q[s][r] <= {en.data, red_q[s][r][`FUSE_W-1:1]};
               end else if (en.rdshift[s][r]) begin
                  red_q[s][r] <= {red_q[s][r][0], red_q[s][r][`FUSE_W-1:1]};
               end
            end
         end
      end
   end

   // Output mux
   // At most one rdshift line is high, zero otherwise
   always_comb begin
      red_fuse_data = 1'b0;
      for (int s = 0; s < `FUSE_NSUB; s++) begin
         for (int r = 0; r < `FUSE_NRID; r++) begin
            red_fuse_data = red_fuse_data | (en.rdshift[s][r] & red_q[s][r][0]);
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/efuse_red_top.sv
// Fuse repair path top
// APB registers, sequencer, data-side header and redundancy bank
`timescale 1ns/1ns
`default_nettype none

module efuse_red_top (
   input  wire        rclk,
   input  wire        rst,
   input  wire        psel,
   input  wire        penable,
   input  wire        pwrite,
   input  wire [7:0]  paddr,
   input  wire [31:0] pwdata,
   output wire [31:0] prdata,
   output wire        pready,
   output wire        pslverr
);

   logic                  start;
   efuse_pkg::fuse_cmd_t  cmd;
   efuse_pkg::fuse_rsp_t  rsp;
   efuse_pkg::fuse_link_t link;
   efuse_pkg::fuse_en_t   en;
   logic                  scdata_efc_fuse_data;
   logic                  red_fuse_data;

   // Bus side
   efuse_regs u_regs (
      .rclk    (rclk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .start   (start),
      .cmd     (cmd),
      .rsp     (rsp)
   );

   efuse_seq u_seq (
      .rclk                 (rclk),
      .rst                  (rst),
      .start                (start),
      .cmd                  (cmd),
      .rsp                  (rsp),
      .link                 (link),
      .scdata_efc_fuse_data (scdata_efc_fuse_data)
   );

   // Data array side
   scdata_fuse_hdr u_hdr (
      .rclk                 (rclk),
      .rst                  (rst),
      .link                 (link),
      .en                   (en),
      .red_fuse_data        (red_fuse_data),
      .scdata_efc_fuse_data (scdata_efc_fuse_data)
   );

   red_fuse_bank u_bank (
      .rclk          (rclk),
      .rst           (rst),
      .en            (en),
      .red_fuse_data (red_fuse_data)
   );

endmodule

`default_nettype wire

// File: tests/efuse_red_tb.sv
// Fuse repair path testbench
// APB driven writes and reads against a redundancy bank model, with refused accesses
`timescale 1ns/1ns
`default_nettype none

`include "efuse_macros.svh"

module efuse_red_tb;

   // Budget per fuse operation plus a few APB accesses around it
   localparam int N_OPS     = 156;
   localparam int OP_CYC    = 40;
   localparam int APB_CYC   = 3;
   localparam int LIMIT_CYC = N_OPS * (OP_CYC + 4 * APB_CYC) + 200;

   logic        clk;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;

   // Reference copy of the bank
   logic [`FUSE_W-1:0] model [`FUSE_NSUB][`FUSE_NRID];
   logic [31:0]        rng;
   int                 errors;
   int                 checks;
   int                 mark;

   efuse_red_top uut (
      .rclk    (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Watchdog
   initial begin
      repeat (LIMIT_CYC) @(posedge clk);
      $display("error: run did not finish within %0d clock cycles", LIMIT_CYC);
      $display("Checks failed");
      $finish;
   end

   // -------------------------------------------------------------------------
   // Random numbers and compares
   // -------------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic compare_fuse(input string name, input logic [`FUSE_W-1:0] got,
                               input logic [`FUSE_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input int num, input string what);
      $display("test %0d %s: %0d errors", num, what, errors - mark);
      mark = errors;
   endtask

   // -------------------------------------------------------------------------
   // APB access
   // -------------------------------------------------------------------------
   // Setup, access, then one idle cycle
   // Response sampled mid access phase
   task automatic apb_access(input logic wr, input logic [7:0] addr,
                             input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      logic rdy;
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      rdata = prdata;
      err   = pslverr;
      rdy   = pready;
      compare_flag("pready", rdy, 1'b1);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] d;
      logic        err;
      apb_access(1'b1, addr, data, d, err);
      compare_flag($sformatf("pslverr write 0x%h", addr), err, 1'b0);
   endtask

   task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
      logic err;
      apb_access(1'b0, addr, 32'd0, data, err);
      compare_flag($sformatf("pslverr read 0x%h", addr), err, 1'b0);
   endtask

   // -------------------------------------------------------------------------
   // Fuse operations
   // -------------------------------------------------------------------------
   // Done set and busy clear
   task automatic wait_done;
      logic [31:0] st;
      int          polls;
      polls = 0;
      st    = '0;
      while (st[1:0] != 2'b10 && polls < 40) begin
         bus_read(`REG_STATUS, st);
         polls++;
      end
      if (st[1:0] != 2'b10) begin
         $display("error: fuse operation still busy after %0d status polls", polls);
         errors++;
      end
   endtask

   task automatic fuse_write(input logic [1:0] sub, input logic [2:0] rid,
                             input logic [`FUSE_W-1:0] word);
      bus_write(`REG_ADDR, {27'd0, sub, rid});
      bus_write(`REG_WDATA, {{(32-`FUSE_W){1'b0}}, word});
      bus_write(`REG_CTRL, 32'h3);
      wait_done();
      model[sub][rid] = word;
   endtask

   task automatic fuse_read(input logic [1:0] sub, input logic [2:0] rid,
                            output logic [`FUSE_W-1:0] word);
      logic [31:0] d;
      bus_write(`REG_ADDR, {27'd0, sub, rid});
      bus_write(`REG_CTRL, 32'h1);
      wait_done();
      bus_read(`REG_RDATA, d);
      word = d[`FUSE_W-1:0];
   endtask

   task automatic verify_loc(input logic [1:0] sub, input logic [2:0] rid);
      logic [`FUSE_W-1:0] got;
      fuse_read(sub, rid, got);
      compare_fuse($sformatf("rdata[%0d][%0d]", sub, rid), got, model[sub][rid]);
   endtask

   task automatic sweep_all;
      for (int s = 0; s < `FUSE_NSUB; s++) begin
         for (int r = 0; r < `FUSE_NRID; r++) begin
            verify_loc(2'(s), 3'(r));
         end
      end
   endtask

   // -------------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------------
   initial begin
      logic [31:0]        d;
      logic               err;
      logic [1:0]         sub;
      logic [2:0]         rid;
      logic [`FUSE_W-1:0] word;
      logic [`FUSE_W-1:0] first;
      logic [`FUSE_W-1:0] second;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      rng     = 32'd68;
      errors  = 0;
      checks  = 0;
      mark    = 0;
      for (int s = 0; s < `FUSE_NSUB; s++) begin
         for (int r = 0; r < `FUSE_NRID; r++) begin
            model[s][r] = '0;
         end
      end
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;

      // Everything idle and zero
      bus_read(`REG_STATUS, d);
      compare_word("prdata status", d, 32'h0);
      bus_read(`REG_RDATA, d);
      compare_word("prdata rdata", d, 32'h0);
      sweep_all();
      finish_test(1, "reset state");

      for (int i = 0; i < 40; i++) begin
         rng  = xorshift32(rng);
         sub  = rng[1:0];
         rid  = 3'(rng[15:8] % `FUSE_NRID);
         word = rng[31:16];
         fuse_write(sub, rid, word);
         rng = xorshift32(rng);
         verify_loc(rng[1:0], 3'(rng[15:8] % `FUSE_NRID));
      end
      finish_test(2, "random write and read");

      // Rotating read must leave the word intact
      // Both end bits set so a word lost by a plain shift shows up
      rng  = xorshift32(rng);
      sub  = rng[1:0];
      rid  = 3'(rng[15:8] % `FUSE_NRID);
      word = rng[31:16] | 16'h8001;
      fuse_write(sub, rid, word);
      fuse_read(sub, rid, first);
      fuse_read(sub, rid, second);
      compare_fuse("rdata first read", first, model[sub][rid]);
      compare_fuse("rdata second read", second, model[sub][rid]);
      finish_test(3, "repeated read");

      sweep_all();
      finish_test(4, "full sweep");

      apb_access(1'b0, 8'h20, 32'd0, d, err);
      compare_flag("pslverr unmapped read", err, 1'b1);
      apb_access(1'b1, 8'h24, 32'hffff_ffff, d, err);
      compare_flag("pslverr unmapped write", err, 1'b1);
      apb_access(1'b1, `REG_RDATA, 32'h1234, d, err);
      compare_flag("pslverr rdata write", err, 1'b1);
      bus_write(`REG_ADDR, {27'd0, 2'd2, 3'd5});
      apb_access(1'b1, `REG_ADDR, {27'd0, 2'd1, 3'd6}, d, err);
      compare_flag("pslverr id 6", err, 1'b1);
      apb_access(1'b1, `REG_ADDR, {27'd0, 2'd3, 3'd7}, d, err);
      compare_flag("pslverr id 7", err, 1'b1);
      bus_read(`REG_ADDR, d);
      compare_word("prdata addr", d, {27'd0, 2'd2, 3'd5});

      // Second start lands while the write is still running
      rng  = xorshift32(rng);
      word = rng[15:0];
      bus_write(`REG_WDATA, {{(32-`FUSE_W){1'b0}}, word});
      bus_write(`REG_CTRL, 32'h3);
      bus_read(`REG_STATUS, d);
      compare_word("prdata status busy", d, 32'h1);
      apb_access(1'b1, `REG_CTRL, 32'h1, d, err);
      compare_flag("pslverr start while busy", err, 1'b1);
      wait_done();
      model[2][5] = word;
      sweep_all();
      finish_test(5, "refused accesses");

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: efuse_red.f
+incdir+rtl
rtl/efuse_pkg.sv
rtl/efuse_regs.sv
rtl/efuse_seq.sv
rtl/scdata_fuse_hdr.sv
rtl/red_fuse_bank.sv
rtl/efuse_red_top.sv
tests/efuse_red_tb.sv
